/* logic/exec_pkg.sv */
`default_nettype none

package exec_pkg;

    localparam int xlen = 32;
    localparam int reg_addr_w = 5;
    localparam int div_steps = 32;
    localparam int div_cnt_w = $clog2(div_steps);
    localparam logic [div_cnt_w-1:0] div_cnt_last = div_cnt_w'(div_steps - 2);

    //////////////////////////////
    // Encodings
    //////////////////////////////

    localparam logic [6:0] opc_op = 7'b0110011;
    localparam logic [6:0] opc_op_imm = 7'b0010011;
    localparam logic [6:0] opc_lui = 7'b0110111;
    localparam logic [6:0] opc_jal = 7'b1101111;
    localparam logic [6:0] opc_branch = 7'b1100011;

    localparam logic [2:0] f3_add = 3'b000;
    localparam logic [2:0] f3_sll = 3'b001;
    localparam logic [2:0] f3_slt = 3'b010;
    localparam logic [2:0] f3_sltu = 3'b011;
    localparam logic [2:0] f3_xor = 3'b100;
    localparam logic [2:0] f3_srl = 3'b101;
    localparam logic [2:0] f3_or = 3'b110;
    localparam logic [2:0] f3_and = 3'b111;
    localparam logic [2:0] f3_divu = 3'b101;
    localparam logic [2:0] f3_remu = 3'b111;
    localparam logic [2:0] f3_beq = 3'b000;
    localparam logic [2:0] f3_bne = 3'b001;
    localparam logic [2:0] f3_blt = 3'b100;
    localparam logic [2:0] f3_bge = 3'b101;

    localparam logic [6:0] f7_base = 7'b0000000;
    localparam logic [6:0] f7_alt = 7'b0100000;
    // M-extension group
    localparam logic [6:0] f7_muldiv = 7'b0000001;

    typedef enum logic [3:0] {
        alu_add,
        alu_sub,
        alu_and,
        alu_or,
        alu_xor,
        alu_slt,
        alu_sltu,
        alu_sll,
        alu_srl,
        alu_pass_b
    } alu_op_t;

    typedef enum logic [1:0] {
        bcu_eq,
        bcu_ne,
        bcu_lt,
        bcu_ge
    } bcu_op_t;

    //////////////////////////////
    // Instruction word
    //////////////////////////////

    typedef struct packed {
        logic [6:0] funct7;
        logic [reg_addr_w-1:0] rs2;
        logic [reg_addr_w-1:0] rs1;
        logic [2:0] funct3;
        logic [reg_addr_w-1:0] rd;
        logic [6:0] opcode;
    } r_fields_t;

    typedef struct packed {
        logic [11:0] imm12;
        logic [reg_addr_w-1:0] rs1;
        logic [2:0] funct3;
        logic [reg_addr_w-1:0] rd;
        logic [6:0] opcode;
    } i_fields_t;

    typedef union packed {
        r_fields_t r_fields;
        i_fields_t i_fields;
    } instr_u;

    typedef struct packed {
        logic valid;
        logic [xlen-1:0] pc;
        instr_u instr;
        logic [xlen-1:0] rdata1;
        logic [xlen-1:0] rdata2;
    } issue_t;

    //////////////////////////////
    // Stage records
    //////////////////////////////

    typedef struct packed {
        logic valid;
        logic [xlen-1:0] pc;
        logic [xlen-1:0] imm;
        logic [xlen-1:0] rdata1;
        logic [xlen-1:0] rdata2;
        logic [reg_addr_w-1:0] waddr;
        logic wren;
        logic use_imm;
        logic lui;
        logic jal;
        logic branch;
        logic division;
        logic rem;
        alu_op_t alu_op;
        bcu_op_t bcu_op;
    } decode_reg_t;

    localparam decode_reg_t init_decode_reg = '0;

    typedef struct packed {
        logic valid;
        logic wren;
        logic [reg_addr_w-1:0] waddr;
        logic [xlen-1:0] wdata;
        logic [xlen-1:0] pc;
    } wb_t;

    typedef struct packed {
        logic valid;
        logic [xlen-1:0] target;
    } jump_t;

    typedef struct packed {
        wb_t wb;
        jump_t jump;
    } execute_reg_t;

    localparam execute_reg_t init_execute_reg = '0;

endpackage

`default_nettype wire

/* logic/int_alu.sv */
`timescale 1ns/1ps
`default_nettype none

module int_alu (
    input logic [exec_pkg::xlen-1:0] a,
    input logic [exec_pkg::xlen-1:0] b,
    input exec_pkg::alu_op_t alu_op,
    input exec_pkg::bcu_op_t bcu_op,
    output logic [exec_pkg::xlen-1:0] result,
    output logic taken
);
    import exec_pkg::*;

    logic [4:0] shamt;
    logic lt_signed, lt_unsigned, equal;

    always_comb begin
        shamt = b[4:0];
        equal = (a == b);
        lt_signed = ($signed(a) < $signed(b));
        lt_unsigned = (a < b);

        case (alu_op)
            alu_add: result = a + b;
            alu_sub: result = a - b;
            alu_and: result = a & b;
            alu_or: result = a | b;
            alu_xor: result = a ^ b;
            alu_slt: result = {{(xlen-1){1'b0}}, lt_signed};
            alu_sltu: result = {{(xlen-1){1'b0}}, lt_unsigned};
            alu_sll: result = a << shamt;
            alu_srl: result = a >> shamt;
            alu_pass_b: result = b;
            default: result = a + b;
        endcase

        // Branch condition on the same operand pair
        case (bcu_op)
            bcu_eq: taken = equal;
            bcu_ne: taken = !equal;
            bcu_lt: taken = lt_signed;
            default: taken = !lt_signed;
        endcase
    end

endmodule

`default_nettype wire

/* logic/serial_divider.sv */
`timescale 1ns/1ps
`default_nettype none

module serial_divider (
    input logic clk,
    input logic rst,
    input logic start,
    input logic [exec_pkg::xlen-1:0] dividend,
    input logic [exec_pkg::xlen-1:0] divisor,
    output logic [exec_pkg::xlen-1:0] quotient,
    output logic [exec_pkg::xlen-1:0] remainder,
    output logic ready
);
    import exec_pkg::*;

    logic [xlen-1:0] rem_q, quo_q, div_q;
    logic [xlen-1:0] rem_in, quo_in, div_in;
    logic [xlen-1:0] rem_next, quo_next;
    logic [xlen:0] trial;
    logic [div_cnt_w-1:0] cnt;
    logic busy;

    //////////////////////////////
    // One restoring step
    //////////////////////////////

    always_comb begin
        // First step works straight on the operands
        if (start) begin
            rem_in = '0;
            quo_in = dividend;
            div_in = divisor;
        end else begin
            rem_in = rem_q;
            quo_in = quo_q;
            div_in = div_q;
        end

        trial = {rem_in, quo_in[xlen-1]} - {1'b0, div_in};

        if (!trial[xlen]) begin
            rem_next = trial[xlen-1:0];
            quo_next = {quo_in[xlen-2:0], 1'b1};
        end else begin
            rem_next = {rem_in[xlen-2:0], quo_in[xlen-1]};
            quo_next = {quo_in[xlen-2:0], 1'b0};
        end
    end

    always_ff @(posedge clk) begin
        if (start || busy) begin
            rem_q <= rem_next;
            quo_q <= quo_next;
            div_q <= div_in;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst) begin
            busy <= 1'b0;
            ready <= 1'b0;
            cnt <= '0;
        end else begin
            ready <= 1'b0;
            if (start) begin
                busy <= 1'b1;
                cnt <= '0;
            end else if (busy) begin
                cnt <= cnt + div_cnt_w'(1);
                if (cnt == div_cnt_last) begin
                    busy <= 1'b0;
                    ready <= 1'b1;
                end
            end
        end
    end

    assign quotient = quo_q;
    assign remainder = rem_q;

endmodule

`default_nettype wire

/* logic/decode_stage.sv */
`timescale 1ns/1ps
`default_nettype none

module decode_stage (
    input logic clk,
    input logic rst,
    input exec_pkg::issue_t issue,
    input logic stall,
    input logic clear,
    output exec_pkg::decode_reg_t dec
);
    import exec_pkg::*;

    decode_reg_t r, v;
    instr_u w;
    logic [xlen-1:0] imm_i, imm_b, imm_j, imm_u;

    always_comb begin
        w = issue.instr;

        // Immediate forms taken from the I-type layout
        imm_i = {{(xlen-12){w.i_fields.imm12[11]}}, w.i_fields.imm12};
        imm_b = {{(xlen-12){w.i_fields.imm12[11]}}, w.i_fields.rd[0],
                 w.i_fields.imm12[10:5], w.i_fields.rd[4:1], 1'b0};
        imm_j = {{(xlen-20){w.i_fields.imm12[11]}}, w.i_fields.rs1, w.i_fields.funct3,
                 w.i_fields.imm12[0], w.i_fields.imm12[10:1], 1'b0};
        imm_u = {w.i_fields.imm12, w.i_fields.rs1, w.i_fields.funct3, 12'b0};

        v = r;

        if (!stall) begin
            v = init_decode_reg;
            if (issue.valid && !clear) begin
                v.valid = 1'b1;
                v.pc = issue.pc;
                v.rdata1 = issue.rdata1;
                v.rdata2 = issue.rdata2;
                v.waddr = w.r_fields.rd;

                case (w.r_fields.opcode)
                    opc_op: begin
                        if (w.r_fields.funct7 == f7_muldiv) begin
                            if (w.r_fields.funct3 == f3_divu || w.r_fields.funct3 == f3_remu) begin
                                v.wren = 1'b1;
                                v.division = 1'b1;
                                v.rem = (w.r_fields.funct3 == f3_remu);
                            end
                        end else if (w.r_fields.funct7 == f7_base) begin
                            v.wren = 1'b1;
                            case (w.r_fields.funct3)
                                f3_add: v.alu_op = alu_add;
                                f3_sll: v.alu_op = alu_sll;
                                f3_slt: v.alu_op = alu_slt;
                                f3_sltu: v.alu_op = alu_sltu;
                                f3_xor: v.alu_op = alu_xor;
                                f3_srl: v.alu_op = alu_srl;
                                f3_or: v.alu_op = alu_or;
                                default: v.alu_op = alu_and;
                            endcase
                        end else if (w.r_fields.funct7 == f7_alt && w.r_fields.funct3 == f3_add) begin
                            v.wren = 1'b1;
                            v.alu_op = alu_sub;
                        end
                    end
                    opc_op_imm: begin
                        v.use_imm = 1'b1;
                        v.imm = imm_i;
                        case (w.i_fields.funct3)
                            f3_add: begin
                                v.wren = 1'b1;
                                v.alu_op = alu_add;
                            end
                            f3_xor: begin
                                v.wren = 1'b1;
                                v.alu_op = alu_xor;
                            end
                            f3_or: begin
                                v.wren = 1'b1;
                                v.alu_op = alu_or;
                            end
                            f3_and: begin
                                v.wren = 1'b1;
                                v.alu_op = alu_and;
                            end
                            default: v.wren = 1'b0;
                        endcase
                    end
                    opc_lui: begin
                        v.wren = 1'b1;
                        v.lui = 1'b1;
                        v.imm = imm_u;
                        v.alu_op = alu_pass_b;
                    end
                    opc_jal: begin
                        v.wren = 1'b1;
                        v.jal = 1'b1;
                        v.imm = imm_j;
                    end
                    opc_branch: begin
                        v.imm = imm_b;
                        v.branch = (w.i_fields.funct3 == f3_beq) || (w.i_fields.funct3 == f3_bne)
                                || (w.i_fields.funct3 == f3_blt) || (w.i_fields.funct3 == f3_bge);
                        case (w.i_fields.funct3)
                            f3_bne: v.bcu_op = bcu_ne;
                            f3_blt: v.bcu_op = bcu_lt;
                            f3_bge: v.bcu_op = bcu_ge;
                            default: v.bcu_op = bcu_eq;
                        endcase
                    end
                    // Unsupported encodings give a valid record that writes nothing
                    default: v.wren = 1'b0;
                endcase
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst) begin
            r <= init_decode_reg;
        end else begin
            r <= v;
        end
    end

    assign dec = r;

endmodule

`default_nettype wire

/* logic/execute_stage.sv */
`timescale 1ns/1ps
`default_nettype none

module execute_stage (
    input logic clk,
    input logic rst,
    input exec_pkg::decode_reg_t dec,
    output logic stall,
    output logic clear,
    output exec_pkg::wb_t wb,
    output exec_pkg::jump_t jump
);
    import exec_pkg::*;

    execute_reg_t r, v;

    logic [xlen-1:0] op_b;
    logic [xlen-1:0] alu_result;
    logic taken;
    logic [xlen-1:0] pc4, target;
    logic [xlen-1:0] quotient, remainder;
    logic div_ready;
    logic div_start;
    logic busy;

    int_alu alu_i (
        .a(dec.rdata1),
        .b(op_b),
        .alu_op(dec.alu_op),
        .bcu_op(dec.bcu_op),
        .result(alu_result),
        .taken(taken)
    );

    serial_divider divider_i (
        .clk(clk),
        .rst(rst),
        .start(div_start),
        .dividend(dec.rdata1),
        .divisor(dec.rdata2),
        .quotient(quotient),
        .remainder(remainder),
        .ready(div_ready)
    );

    always_comb begin
        op_b = dec.use_imm ? dec.imm : dec.rdata2;
        pc4 = dec.pc + xlen'(4);
        target = dec.pc + dec.imm;

        // Divide holds the stage until the result is back
        div_start = dec.valid && dec.division && !busy;
        stall = dec.valid && dec.division && !div_ready;

        v = r;

        v.wb.valid = dec.valid;
        v.wb.wren = dec.wren;
        v.wb.waddr = dec.waddr;
        v.wb.pc = dec.pc;

        if (dec.lui) begin
            v.wb.wdata = dec.imm;
        end else if (dec.jal) begin
            v.wb.wdata = pc4;
        end else if (dec.division) begin
            v.wb.wdata = dec.rem ? remainder : quotient;
        end else begin
            v.wb.wdata = alu_result;
        end

        v.jump.valid = dec.valid && (dec.jal || (dec.branch && taken));
        if (v.jump.valid) begin
            v.jump.target = target;
        end

        if (stall) begin
            v.wb.valid = 1'b0;
            v.wb.wren = 1'b0;
            v.jump.valid = 1'b0;
        end

        // Younger instruction in decode is flushed
        clear = v.jump.valid;
    end

    always_ff @(posedge clk) begin
        if (!rst) begin
            r <= init_execute_reg;
        end else begin
            r <= v;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst) begin
            busy <= 1'b0;
        end else if (div_start) begin
            busy <= 1'b1;
        end else if (div_ready) begin
            busy <= 1'b0;
        end
    end

    assign wb = r.wb;
    assign jump = r.jump;

endmodule

`default_nettype wire

/* logic/exec_pipe.sv */
`timescale 1ns/1ps
`default_nettype none

module exec_pipe (
    input logic clk,
    input logic rst,
    input exec_pkg::issue_t issue,
    output logic stall,
    output exec_pkg::wb_t wb,
    output exec_pkg::jump_t jump
);
    import exec_pkg::*;

    decode_reg_t dec;
    logic clear;

    //////////////////////////////
    // Decode then execute
    //////////////////////////////

    decode_stage decode_i (
        .clk(clk),
        .rst(rst),
        .issue(issue),
        .stall(stall),
        .clear(clear),
        .dec(dec)
    );

    execute_stage execute_i (
        .clk(clk),
        .rst(rst),
        .dec(dec),
        .stall(stall),
        .clear(clear),
        .wb(wb),
        .jump(jump)
    );

endmodule

`default_nettype wire

/* tb/tb_clock.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_clock (
    output logic clk,
    output logic rst
);
    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // Reset held low for 16 cycles
    initial begin
        rst = 1'b0;
        repeat (16) @(posedge clk);
        rst <= 1'b1;
    end

endmodule

`default_nettype wire

/* tb/exec_checker.sv */
`timescale 1ns/1ps
`default_nettype none

module exec_checker (
    input logic clk,
    input logic rst,
    input exec_pkg::issue_t issue,
    input logic stall,
    input exec_pkg::wb_t wb,
    input exec_pkg::jump_t jump,
    input logic report,
    output int error_count,
    output logic idle,
    output logic reported
);
    import exec_pkg::*;

    localparam int n_tests = 6;
    localparam int wb_timeout = 100;

    typedef struct packed {
        int accept_cycle;
        int latency;
        int test;
        logic wren;
        logic [4:0] waddr;
        logic [31:0] wdata;
        logic [31:0] pc;
        logic jump_valid;
        logic [31:0] target;
    } expect_t;

    expect_t pending[$];
    int checks[n_tests];
    int errors[n_tests];
    bit flushed[logic [31:0]];
    int cycle = 0;
    int jump_cycle = -10;
    int after_reset = 0;

    initial begin
        error_count = 0;
        idle = 1'b1;
        reported = 1'b0;
        for (int i = 0; i < n_tests; i++) begin
            checks[i] = 0;
            errors[i] = 0;
        end
    end

    function automatic string test_name(input int t);
        case (t)
            0: return "alu_ops";
            1: return "lui_unsupported";
            2: return "branch_jal";
            3: return "flush";
            4: return "divide";
            default: return "reset_idle";
        endcase
    endfunction

    task automatic compare(input int t, input string what, input logic [31:0] exp,
                           input logic [31:0] act);
        checks[t]++;
        if (exp !== act) begin
            errors[t]++;
            $display("Error %s %s: expected %h, actual %h", test_name(t), what, exp, act);
        end
    endtask

    //////////////////////////////
    // Reference model
    //////////////////////////////

    function automatic expect_t predict(input issue_t is, input int cyc);
        expect_t e;
        logic [31:0] w, a, b;
        logic [31:0] imm_i, imm_b, imm_j, imm_u;
        logic [6:0] opc, f7;
        logic [2:0] f3;
        logic cond;
        w = is.instr;
        a = is.rdata1;
        b = is.rdata2;
        opc = w[6:0];
        f3 = w[14:12];
        f7 = w[31:25];
        imm_i = {{20{w[31]}}, w[31:20]};
        imm_b = {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
        imm_j = {{11{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
        imm_u = {w[31:12], 12'b0};
        cond = 1'b0;
        e = '0;
        e.accept_cycle = cyc;
        e.latency = 2;
        e.pc = is.pc;
        e.waddr = w[11:7];
        e.test = 1;
        case (opc)
            7'b0110011: begin
                e.test = 0;
                e.wren = 1'b1;
                if (f7 == 7'h01) begin
                    e.wren = (f3 == 3'b101) || (f3 == 3'b111);
                    if (e.wren) begin
                        e.test = 4;
                        e.latency = 34;
                    end
                    if (b == 0) begin
                        e.wdata = (f3 == 3'b101) ? 32'hffff_ffff : a;
                    end else begin
                        e.wdata = (f3 == 3'b101) ? a / b : a % b;
                    end
                end else if (f7 == 7'h20) begin
                    e.wren = (f3 == 3'b000);
                    e.wdata = a - b;
                end else if (f7 == 7'h00) begin
                    case (f3)
                        3'b000: e.wdata = a + b;
                        3'b001: e.wdata = a << b[4:0];
                        3'b010: e.wdata = {31'b0, $signed(a) < $signed(b)};
                        3'b011: e.wdata = {31'b0, a < b};
                        3'b100: e.wdata = a ^ b;
                        3'b101: e.wdata = a >> b[4:0];
                        3'b110: e.wdata = a | b;
                        default: e.wdata = a & b;
                    endcase
                end else begin
                    e.wren = 1'b0;
                end
            end
            7'b0010011: begin
                e.test = 0;
                e.wren = 1'b1;
                case (f3)
                    3'b000: e.wdata = a + imm_i;
                    3'b100: e.wdata = a ^ imm_i;
                    3'b110: e.wdata = a | imm_i;
                    3'b111: e.wdata = a & imm_i;
                    default: e.wren = 1'b0;
                endcase
            end
            7'b0110111: begin
                e.wren = 1'b1;
                e.wdata = imm_u;
            end
            7'b1101111: begin
                e.test = 2;
                e.wren = 1'b1;
                e.wdata = is.pc + 32'd4;
                e.jump_valid = 1'b1;
                e.target = is.pc + imm_j;
            end
            7'b1100011: begin
                e.test = 2;
                case (f3)
                    3'b000: cond = (a == b);
                    3'b001: cond = (a != b);
                    3'b100: cond = $signed(a) < $signed(b);
                    3'b101: cond = $signed(a) >= $signed(b);
                    default: cond = 1'b0;
                endcase
                e.jump_valid = cond;
                e.target = is.pc + imm_b;
            end
            default: e.wren = 1'b0;
        endcase
        return e;
    endfunction

    //////////////////////////////
    // Compare on every edge
    //////////////////////////////

    always @(posedge clk) begin
        expect_t e;
        int total;
        if (!rst) begin
            // Registers take their reset value at the first edge
            if (cycle > 0) begin
                compare(5, "valid/jump/stall", 32'd0, {29'd0, wb.valid, jump.valid, stall});
            end
            pending.delete();
            after_reset = 2;
        end else begin
            if (after_reset > 0) begin
                compare(5, "valid/jump/stall", 32'd0, {29'd0, wb.valid, jump.valid, stall});
                after_reset--;
            end
            if (wb.valid) begin
                if (flushed.exists(wb.pc)) begin
                    errors[3]++;
                    $display("Flushed instruction at pc %h reached writeback", wb.pc);
                end
                if (pending.size() == 0) begin
                    errors[0]++;
                    $display("Writeback at pc %h arrived with no instruction pending", wb.pc);
                end else begin
                    e = pending.pop_front();
                    compare(e.test, "latency", e.latency, cycle - e.accept_cycle);
                    compare(e.test, "pc", e.pc, wb.pc);
                    compare(e.test, "wren", {31'd0, e.wren}, {31'd0, wb.wren});
                    if (e.wren) begin
                        compare(e.test, "waddr", {27'd0, e.waddr}, {27'd0, wb.waddr});
                        compare(e.test, "wdata", e.wdata, wb.wdata);
                    end
                    compare(e.test, "jump", {31'd0, e.jump_valid}, {31'd0, jump.valid});
                    if (e.jump_valid) begin
                        compare(e.test, "target", e.target, jump.target);
                    end
                end
            end else if (jump.valid) begin
                errors[2]++;
                $display("Jump raised without a writeback record");
            end
            if (pending.size() > 0 && cycle - pending[0].accept_cycle > wb_timeout) begin
                errors[pending[0].test]++;
                $display("No writeback within %0d cycles for pc %h", wb_timeout, pending[0].pc);
                void'(pending.pop_front());
            end
            if (issue.valid && !stall) begin
                // Younger instruction behind a taken jump is dropped
                if (cycle == jump_cycle + 1) begin
                    flushed[issue.pc] = 1'b1;
                    checks[3]++;
                end else begin
                    e = predict(issue, cycle);
                    pending.push_back(e);
                    if (e.jump_valid) begin
                        jump_cycle = cycle;
                    end
                end
            end
        end
        total = 0;
        for (int i = 0; i < n_tests; i++) begin
            total += errors[i];
        end
        if (report && !reported) begin
            for (int i = 0; i < n_tests; i++) begin
                $display("%-16s checks %0d errors %0d", test_name(i), checks[i], errors[i]);
            end
            $display("Tests %0d, checks %0d, errors %0d", n_tests,
                     checks.sum(), total);
            reported <= 1'b1;
        end
        error_count <= total;
        idle <= (pending.size() == 0);
        cycle = cycle + 1;
    end

endmodule

`default_nettype wire

/* tb/exec_pipe_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module exec_pipe_tb;
    import exec_pkg::*;

    localparam int n_instr = 500;

    logic clk, rst;
    issue_t issue;
    logic stall;
    wb_t wb;
    jump_t jump;
    logic report;
    int error_count;
    logic idle, reported;
    int seed = 22;
    int accepted = 0;
    bit timed_out = 1'b0;
    logic [31:0] next_pc = 32'h0000_1000;

    tb_clock clock_i (.clk(clk), .rst(rst));

    exec_pipe exec_pipe_i (
        .clk(clk),
        .rst(rst),
        .issue(issue),
        .stall(stall),
        .wb(wb),
        .jump(jump)
    );

    exec_checker checker_i (
        .clk(clk), .rst(rst), .issue(issue), .stall(stall), .wb(wb), .jump(jump),
        .report(report), .error_count(error_count), .idle(idle), .reported(reported)
    );

    task automatic make_instruction(input logic [31:0] pc, output issue_t it);
        int cls;
        int mode;
        logic [31:0] r;
        logic [2:0] f3;
        logic [6:0] f7;
        cls = $unsigned($random(seed)) % 32'd8;
        mode = $unsigned($random(seed)) % 32'd4;
        r = $random(seed);
        f3 = r[14:12];
        f7 = 7'h00;
        it.valid = ($unsigned($random(seed)) % 32'd4) != 0;
        it.pc = pc;
        it.rdata1 = $random(seed);
        it.rdata2 = $random(seed);
        // Zero and equal operands reach divide-by-zero and branch-equal
        if (mode == 0) begin
            it.rdata2 = '0;
        end else if (mode == 1) begin
            it.rdata2 = it.rdata1;
        end else if (mode == 2) begin
            it.rdata2 = it.rdata2 & 32'hff;
        end
        case (cls)
            0: it.instr = {r[31:7], (r[0] ? 7'b0000011 : 7'b1110011)};
            1, 2: begin
                if (f3 == 3'b000 && r[1]) begin
                    f7 = 7'h20;
                end
                it.instr = {f7, r[24:15], f3, r[11:7], opc_op};
            end
            3: it.instr = {r[31:7], opc_op_imm};
            4: it.instr = {r[31:7], opc_lui};
            5: it.instr = {r[31:7], opc_jal};
            6: begin
                f3 = {r[1], 1'b0, r[0]};
                it.instr = {r[31:15], f3, r[11:7], opc_branch};
            end
            default: begin
                f3 = r[0] ? f3_remu : f3_divu;
                it.instr = {f7_muldiv, r[24:15], f3, r[11:7], opc_op};
            end
        endcase
    endtask

    initial begin
        int guard;
        issue_t it;
        issue = '0;
        report = 1'b0;

        guard = 0;
        while (!rst && !timed_out) begin
            @(posedge clk);
            guard++;
            if (guard > 100) begin
                timed_out = 1'b1;
                $display("Timeout: reset never released");
            end
        end

        // Drive and hold while stalled
        guard = 0;
        while (accepted < n_instr && !timed_out) begin
            @(posedge clk);
            guard++;
            if (!stall) begin
                if (issue.valid) begin
                    accepted++;
                end
                if (accepted < n_instr) begin
                    make_instruction(next_pc, it);
                    next_pc = next_pc + 32'd4;
                    issue <= it;
                end else begin
                    issue <= '0;
                end
            end
            if (guard > 100000) begin
                timed_out = 1'b1;
                $display("Timeout: instructions were not accepted");
            end
        end

        guard = 0;
        while (!timed_out && !(idle && guard > 2)) begin
            @(posedge clk);
            guard++;
            if (guard > 200) begin
                timed_out = 1'b1;
                $display("Timeout: pipeline did not drain");
            end
        end

        report <= 1'b1;
        guard = 0;
        while (!reported && !timed_out) begin
            @(posedge clk);
            guard++;
            if (guard > 10) begin
                timed_out = 1'b1;
                $display("Timeout: checker gave no summary");
            end
        end
        @(posedge clk);

        if (timed_out || error_count != 0) begin
            $display("Errors found");
        end else begin
            $display("No errors");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* exec_pipe.f */
logic/exec_pkg.sv
logic/int_alu.sv
logic/serial_divider.sv
logic/decode_stage.sv
logic/execute_stage.sv
logic/exec_pipe.sv
tb/tb_clock.sv
tb/exec_checker.sv
tb/exec_pipe_tb.sv

/* run.sh */
#!/bin/sh
# Build with Verilator and run; the status follows the testbench verdict
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f exec_pipe.f --top-module exec_pipe_tb \
    || { echo "Build failed"; exit 1; }

out=$(./obj_dir/Vexec_pipe_tb 2>&1)
printf '%s\n' "$out"
printf '%s\n' "$out" | grep -qx "No errors" && exit 0 || exit 1
